// File: common/rv_isa_pkg.sv
// RV64I encodings and widths, imported by any block that handles raw instruction words
`default_nettype none

package rv_isa_pkg;

    // register width, fixed by the base ISA
    localparam int XLEN = 64;

    // one 32-bit instruction word
    typedef logic [31:0] inst_t;

    // index into the 32-entry integer register file
    typedef logic [4:0] reg_addr_t;

    // field layout of the R and I formats
    //   inst[6:0]    opcode
    //   inst[11:7]   rd
    //   inst[14:12]  funct3
    //   inst[19:15]  rs1
    //   inst[24:20]  rs2, or low bits of the immediate
    //   inst[31:20]  12-bit immediate
    //   inst[31:26]  upper funct bits, above the 6-bit shamt

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // upper funct bits selecting sub, sra and srai
    // in OP the bit below them (inst[25]) must also be zero
    localparam logic [5:0] F6_SRA_SUB = 6'b010000;

endpackage

`default_nettype wire

// File: common/core_pkg.sv
// core-internal data types and ALU operation codes, shared by decode, execute and register file
`default_nettype none

package core_pkg;

    // one register or ALU value
    typedef logic [rv_isa_pkg::XLEN-1:0] xdata_t;

    // internal operation code
    // upper nibble is the instruction type, lower nibble the operation within it
    typedef logic [7:0] alu_op_t;

    // type nibbles
    localparam logic [3:0] TYPE_ARITH = 4'h1;
    localparam logic [3:0] TYPE_LOGIC = 4'h2;
    localparam logic [3:0] TYPE_SHIFT = 4'h3;

    // unsupported encoding, never executed
    localparam alu_op_t OP_NONE = 8'h00;

    // arithmetic and compare
    // add and addi share one code
    localparam alu_op_t OP_ADD  = {TYPE_ARITH, 4'h1};
    localparam alu_op_t OP_SUB  = {TYPE_ARITH, 4'h2};
    localparam alu_op_t OP_SLT  = {TYPE_ARITH, 4'h3};
    localparam alu_op_t OP_SLTU = {TYPE_ARITH, 4'h4};

    // bitwise logic
    localparam alu_op_t OP_AND  = {TYPE_LOGIC, 4'h1};
    localparam alu_op_t OP_OR   = {TYPE_LOGIC, 4'h2};
    localparam alu_op_t OP_XOR  = {TYPE_LOGIC, 4'h3};

    // shifts, amount taken from the low 6 bits of operand 2
    localparam alu_op_t OP_SLL  = {TYPE_SHIFT, 4'h1};
    localparam alu_op_t OP_SRL  = {TYPE_SHIFT, 4'h2};
    localparam alu_op_t OP_SRA  = {TYPE_SHIFT, 4'h3};

endpackage

`default_nettype wire

// File: hdl/regfile.sv
// 32x64 integer register file with two combinational read ports and write-through
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        rs1_r_ena,
    input  wire rv_isa_pkg::reg_addr_t rs1_r_addr,
    input  wire                        rs2_r_ena,
    input  wire rv_isa_pkg::reg_addr_t rs2_r_addr,
    input  wire                        rd_w_ena,
    input  wire rv_isa_pkg::reg_addr_t rd_w_addr,
    input  wire core_pkg::xdata_t      rd_w_data,
    output core_pkg::xdata_t           rs1_data,
    output core_pkg::xdata_t           rs2_data
);

    import core_pkg::*;

    // x0 has no storage
    xdata_t regs [1:31];

    // disabled port and x0 read zero; a same-cycle write is passed straight through
    function automatic xdata_t read_port(input logic ena, input rv_isa_pkg::reg_addr_t addr);
        xdata_t val;
        if (!ena || addr == '0) begin
            val = '0;
        end else if (rd_w_ena && rd_w_addr == addr) begin
            val = rd_w_data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_w_ena) begin
            // decode never enables a write to x0
            regs[rd_w_addr] <= rd_w_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_r_ena, rs1_r_addr);
        rs2_data = read_port(rs2_r_ena, rs2_r_addr);
    end

endmodule

`default_nettype wire

// File: hdl/id_stage.sv
// decode stage: turns an instruction into an ALU op and operands, registered into execute
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire rv_isa_pkg::inst_t     inst,
    input  wire                        inst_valid,
    output logic                       rs1_r_ena,
    output rv_isa_pkg::reg_addr_t      rs1_r_addr,
    output logic                       rs2_r_ena,
    output rv_isa_pkg::reg_addr_t      rs2_r_addr,
    input  wire core_pkg::xdata_t      rs1_data,
    input  wire core_pkg::xdata_t      rs2_data,
    input  wire core_pkg::xdata_t      fwd_data,
    output logic                       ex_valid,
    output core_pkg::alu_op_t          ex_op,
    output core_pkg::xdata_t           ex_op1,
    output core_pkg::xdata_t           ex_op2,
    output logic                       ex_rd_w_ena,
    output rv_isa_pkg::reg_addr_t      ex_rd_w_addr
);

    import rv_isa_pkg::*;
    import core_pkg::*;

    // instruction fields
    logic [6:0]  opcode;
    reg_addr_t   rd;
    logic [2:0]  funct3;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm;
    logic [5:0]  shamt;
    logic [5:0]  funct6;
    logic        f7_lsb;

    logic        is_imm;
    logic        is_reg;
    logic        is_shift_imm;
    alu_op_t     dec_op;
    logic        fwd_rs1;
    logic        fwd_rs2;
    xdata_t      rs2_val;
    xdata_t      op1;
    xdata_t      op2;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign imm    = inst[31:20];
    assign shamt  = inst[25:20];
    assign funct6 = inst[31:26];
    assign f7_lsb = inst[25];

    assign is_imm       = (opcode == OPC_OP_IMM);
    assign is_reg       = (opcode == OPC_OP);
    assign is_shift_imm = is_imm && (funct3 == F3_SLL || funct3 == F3_SRL_SRA);

    // encoding to internal op, anything not matched stays OP_NONE
    always_comb begin
        dec_op = OP_NONE;
        if (is_imm) begin
            case (funct3)
                F3_ADD_SUB: dec_op = OP_ADD;
                F3_SLT:     dec_op = OP_SLT;
                F3_SLTU:    dec_op = OP_SLTU;
                F3_XOR:     dec_op = OP_XOR;
                F3_OR:      dec_op = OP_OR;
                F3_AND:     dec_op = OP_AND;
                F3_SLL: begin
                    if (funct6 == '0) dec_op = OP_SLL;
                end
                F3_SRL_SRA: begin
                    if (funct6 == '0) begin
                        dec_op = OP_SRL;
                    end else if (funct6 == F6_SRA_SUB) begin
                        dec_op = OP_SRA;
                    end
                end
                default: dec_op = OP_NONE;
            endcase
        end else if (is_reg && !f7_lsb) begin
            if (funct6 == '0) begin
                case (funct3)
                    F3_ADD_SUB: dec_op = OP_ADD;
                    F3_SLL:     dec_op = OP_SLL;
                    F3_SLT:     dec_op = OP_SLT;
                    F3_SLTU:    dec_op = OP_SLTU;
                    F3_XOR:     dec_op = OP_XOR;
                    F3_SRL_SRA: dec_op = OP_SRL;
                    F3_OR:      dec_op = OP_OR;
                    default:    dec_op = OP_AND;
                endcase
            end else if (funct6 == F6_SRA_SUB) begin
                // only sub and sra exist with the alternate funct bits
                if (funct3 == F3_ADD_SUB) begin
                    dec_op = OP_SUB;
                end else if (funct3 == F3_SRL_SRA) begin
                    dec_op = OP_SRA;
                end
            end
        end
    end

    // register file reads
    assign rs1_r_ena  = inst_valid && (is_imm || is_reg);
    assign rs1_r_addr = rs1;
    assign rs2_r_ena  = inst_valid && is_reg;
    assign rs2_r_addr = rs2;

    // bypass from the instruction now in execute; its enable already implies rd != x0
    assign fwd_rs1 = ex_rd_w_ena && (ex_rd_w_addr == rs1);
    assign fwd_rs2 = ex_rd_w_ena && (ex_rd_w_addr == rs2);

    assign op1     = fwd_rs1 ? fwd_data : rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_data : rs2_data;

    always_comb begin
        if (is_reg) begin
            op2 = rs2_val;
        end else if (is_shift_imm) begin
            op2 = {{(XLEN-6){1'b0}}, shamt};
        end else begin
            op2 = {{(XLEN-12){imm[11]}}, imm};
        end
    end

    // decode/execute pipeline register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_op        <= OP_NONE;
            ex_op1       <= '0;
            ex_op2       <= '0;
            ex_rd_w_ena  <= 1'b0;
            ex_rd_w_addr <= '0;
        end else begin
            ex_valid     <= inst_valid;
            ex_op        <= dec_op;
            ex_op1       <= op1;
            ex_op2       <= op2;
            ex_rd_w_ena  <= inst_valid && (dec_op != OP_NONE) && (rd != '0);
            ex_rd_w_addr <= rd;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exe_stage.sv
// execute stage: 64-bit ALU with registered writeback and bad-instruction strobe
`timescale 1ns/100ps
`default_nettype none

module exe_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        ex_valid,
    input  wire core_pkg::alu_op_t     ex_op,
    input  wire core_pkg::xdata_t      ex_op1,
    input  wire core_pkg::xdata_t      ex_op2,
    input  wire                        ex_rd_w_ena,
    input  wire rv_isa_pkg::reg_addr_t ex_rd_w_addr,
    output core_pkg::xdata_t           fwd_data,
    output logic                       rd_w_ena,
    output rv_isa_pkg::reg_addr_t      rd_w_addr,
    output core_pkg::xdata_t           rd_w_data,
    output logic                       bad_inst
);

    import core_pkg::*;

    logic [3:0] op_type;
    logic [5:0] sh_amt;
    xdata_t     arith_res;
    xdata_t     logic_res;
    xdata_t     shift_res;
    xdata_t     alu_res;

    assign op_type = ex_op[7:4];
    assign sh_amt  = ex_op2[5:0];

    // add, sub and compares
    always_comb begin
        case (ex_op)
            OP_SUB:  arith_res = ex_op1 - ex_op2;
            OP_SLT:  arith_res = xdata_t'($signed(ex_op1) < $signed(ex_op2));
            OP_SLTU: arith_res = xdata_t'(ex_op1 < ex_op2);
            default: arith_res = ex_op1 + ex_op2;
        endcase
    end

    always_comb begin
        case (ex_op)
            OP_AND:  logic_res = ex_op1 & ex_op2;
            OP_OR:   logic_res = ex_op1 | ex_op2;
            default: logic_res = ex_op1 ^ ex_op2;
        endcase
    end

    // sra keeps the sign of operand 1
    always_comb begin
        case (ex_op)
            OP_SRL:  shift_res = ex_op1 >> sh_amt;
            OP_SRA:  shift_res = xdata_t'($signed(ex_op1) >>> sh_amt);
            default: shift_res = ex_op1 << sh_amt;
        endcase
    end

    // type nibble picks the unit
    always_comb begin
        case (op_type)
            TYPE_ARITH: alu_res = arith_res;
            TYPE_LOGIC: alu_res = logic_res;
            TYPE_SHIFT: alu_res = shift_res;
            default:    alu_res = '0;
        endcase
    end

    // same-cycle result for the instruction being decoded
    assign fwd_data = alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_w_ena  <= 1'b0;
            rd_w_addr <= '0;
            rd_w_data <= '0;
            bad_inst  <= 1'b0;
        end else begin
            rd_w_ena  <= ex_valid && ex_rd_w_ena;
            rd_w_addr <= ex_rd_w_addr;
            rd_w_data <= alu_res;
            bad_inst  <= ex_valid && (ex_op == OP_NONE);
        end
    end

endmodule

`default_nettype wire

// File: hdl/core_top.sv
// top of the RV64I integer core: decode, execute and register file, writes reported at the ports
`timescale 1ns/100ps
`default_nettype none

module core_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire rv_isa_pkg::inst_t     inst,
    input  wire                        inst_valid,
    output logic                       wb_valid,
    output rv_isa_pkg::reg_addr_t      wb_addr,
    output core_pkg::xdata_t           wb_data,
    output logic                       bad_inst
);

    import rv_isa_pkg::*;
    import core_pkg::*;

    // register file read side
    logic      rs1_r_ena;
    reg_addr_t rs1_r_addr;
    logic      rs2_r_ena;
    reg_addr_t rs2_r_addr;
    xdata_t    rs1_data;
    xdata_t    rs2_data;

    // decode to execute
    logic      ex_valid;
    alu_op_t   ex_op;
    xdata_t    ex_op1;
    xdata_t    ex_op2;
    logic      ex_rd_w_ena;
    reg_addr_t ex_rd_w_addr;
    xdata_t    fwd_data;

    // writeback
    logic      rd_w_ena;
    reg_addr_t rd_w_addr;
    xdata_t    rd_w_data;

    id_stage u_id_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .rs1_r_ena    (rs1_r_ena),
        .rs1_r_addr   (rs1_r_addr),
        .rs2_r_ena    (rs2_r_ena),
        .rs2_r_addr   (rs2_r_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .fwd_data     (fwd_data),
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .ex_op1       (ex_op1),
        .ex_op2       (ex_op2),
        .ex_rd_w_ena  (ex_rd_w_ena),
        .ex_rd_w_addr (ex_rd_w_addr)
    );

    exe_stage u_exe_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .ex_op1       (ex_op1),
        .ex_op2       (ex_op2),
        .ex_rd_w_ena  (ex_rd_w_ena),
        .ex_rd_w_addr (ex_rd_w_addr),
        .fwd_data     (fwd_data),
        .rd_w_ena     (rd_w_ena),
        .rd_w_addr    (rd_w_addr),
        .rd_w_data    (rd_w_data),
        .bad_inst     (bad_inst)
    );

    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_r_ena  (rs1_r_ena),
        .rs1_r_addr (rs1_r_addr),
        .rs2_r_ena  (rs2_r_ena),
        .rs2_r_addr (rs2_r_addr),
        .rd_w_ena   (rd_w_ena),
        .rd_w_addr  (rd_w_addr),
        .rd_w_data  (rd_w_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    // the register file write is also the reported writeback
    assign wb_valid = rd_w_ena;
    assign wb_addr  = rd_w_addr;
    assign wb_data  = rd_w_data;

endmodule

`default_nettype wire

// File: verification/tb_core.sv
// testbench for core_top with a directed table, then random instructions against a register model
`timescale 1ns/100ps
`default_nettype none

module tb_core;

    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam logic [6:0] F7_BASE       = 7'b0000000;
    localparam logic [6:0] F7_ALT        = {F6_SRA_SUB, 1'b0};
    localparam int         RAND_COUNT    = 200;
    localparam int         DRAIN_TIMEOUT = 20;

    logic        clk;
    logic        rst_n;
    inst_t       inst;
    logic        inst_valid;
    logic        wb_valid;
    reg_addr_t   wb_addr;
    xdata_t      wb_data;
    logic        bad_inst;

    int unsigned cyc_cnt = 0;
    xdata_t      ref_regs [32];

    // directed table with one entry per instruction
    inst_t       tbl_inst [$];
    int          tbl_gap  [$];
    reg_addr_t   tbl_addr [$];
    xdata_t      tbl_data [$];
    logic        tbl_bad  [$];

    // strobes still owed by the core in issue order
    int unsigned exp_cyc_q  [$];
    reg_addr_t   exp_addr_q [$];
    xdata_t      exp_data_q [$];
    logic        exp_bad_q  [$];

    core_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .bad_inst   (bad_inst)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

    task automatic abort_run(input string why);
        $display("%0d ns: %s", $time, why);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: %s mismatch, got 0x%h, expected 0x%h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic inst_t enc_i(input logic [2:0] f3, input reg_addr_t rd,
                                    input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic inst_t enc_sh(input logic [5:0] f6, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input logic [5:0] shamt);
        return {f6, shamt, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // RV64I result of one OP or OP-IMM instruction
    function automatic xdata_t ref_result(input inst_t w, input xdata_t a, input xdata_t rs2_val);
        xdata_t     b;
        logic [5:0] sh;
        logic       alt;
        xdata_t     r;
        b   = (w[6:0] == OPC_OP) ? rs2_val : {{52{w[31]}}, w[31:20]};
        sh  = b[5:0];
        alt = w[30];
        case (w[14:12])
            F3_ADD_SUB: r = (w[6:0] == OPC_OP && alt) ? a - b : a + b;
            F3_SLL:     r = a << sh;
            F3_SLT:     r = {63'd0, $signed(a) < $signed(b)};
            F3_SLTU:    r = {63'd0, a < b};
            F3_XOR:     r = a ^ b;
            F3_SRL_SRA: r = alt ? xdata_t'($signed(a) >>> sh) : a >> sh;
            F3_OR:      r = a | b;
            default:    r = a & b;
        endcase
        return r;
    endfunction

    task automatic add_entry(input inst_t w, input int gap, input reg_addr_t addr,
                             input xdata_t data, input logic bad);
        tbl_inst.push_back(w);
        tbl_gap.push_back(gap);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
        tbl_bad.push_back(bad);
    endtask

    // expected addr 0 with bad 0 means no strobe at all
    task automatic build_table();
        add_entry(enc_i(F3_ADD_SUB, 5'd1, 5'd0, 12'd5), 2, 5'd1, 64'd5, 1'b0);
        add_entry(enc_i(F3_ADD_SUB, 5'd2, 5'd0, -12'd3), 0, 5'd2, -64'd3, 1'b0);
        add_entry(enc_i(F3_ADD_SUB, 5'd3, 5'd1, 12'h7FF), 3, 5'd3, 64'h804, 1'b0);
        add_entry(enc_i(F3_SLT, 5'd4, 5'd2, -12'd2), 1, 5'd4, 64'd1, 1'b0);
        add_entry(enc_i(F3_SLTU, 5'd5, 5'd2, 12'd5), 0, 5'd5, 64'd0, 1'b0);
        add_entry(enc_i(F3_XOR, 5'd6, 5'd1, -12'd1), 0, 5'd6, -64'd6, 1'b0);
        add_entry(enc_i(F3_OR, 5'd7, 5'd1, 12'h0F0), 0, 5'd7, 64'hF5, 1'b0);
        add_entry(enc_i(F3_AND, 5'd8, 5'd2, 12'h0FF), 0, 5'd8, 64'hFD, 1'b0);
        add_entry(enc_sh(6'd0, F3_SLL, 5'd9, 5'd1, 6'd60), 0, 5'd9, 64'h5 << 60, 1'b0);
        add_entry(enc_sh(6'd0, F3_SRL_SRA, 5'd10, 5'd2, 6'd60), 0, 5'd10, 64'hF, 1'b0);
        add_entry(enc_sh(F6_SRA_SUB, F3_SRL_SRA, 5'd11, 5'd2, 6'd1), 0, 5'd11, -64'd2, 1'b0);
        // register-register group
        add_entry(enc_r(F7_BASE, F3_ADD_SUB, 5'd12, 5'd1, 5'd2), 2, 5'd12, 64'd2, 1'b0);
        add_entry(enc_r(F7_ALT, F3_ADD_SUB, 5'd13, 5'd1, 5'd2), 0, 5'd13, 64'd8, 1'b0);
        add_entry(enc_r(F7_BASE, F3_AND, 5'd15, 5'd6, 5'd7), 0, 5'd15, 64'hF0, 1'b0);
        add_entry(enc_r(F7_BASE, F3_OR, 5'd16, 5'd2, 5'd1), 0, 5'd16, -64'd3, 1'b0);
        add_entry(enc_r(F7_BASE, F3_XOR, 5'd17, 5'd2, 5'd1), 0, 5'd17, -64'd8, 1'b0);
        add_entry(enc_r(F7_BASE, F3_SLT, 5'd18, 5'd2, 5'd1), 0, 5'd18, 64'd1, 1'b0);
        add_entry(enc_r(F7_BASE, F3_SLTU, 5'd19, 5'd2, 5'd1), 0, 5'd19, 64'd0, 1'b0);
        add_entry(enc_r(F7_BASE, F3_SLTU, 5'd20, 5'd1, 5'd2), 0, 5'd20, 64'd1, 1'b0);
        add_entry(enc_r(F7_BASE, F3_SLT, 5'd21, 5'd1, 5'd2), 0, 5'd21, 64'd0, 1'b0);
        add_entry(enc_r(F7_BASE, F3_SLL, 5'd22, 5'd1, 5'd3), 0, 5'd22, 64'h50, 1'b0);
        add_entry(enc_r(F7_BASE, F3_SRL_SRA, 5'd23, 5'd2, 5'd1), 0, 5'd23, -64'd1 >> 5, 1'b0);
        add_entry(enc_r(F7_ALT, F3_SRL_SRA, 5'd24, 5'd2, 5'd1), 0, 5'd24, -64'd1, 1'b0);
        // dependent pairs with gaps of 0, 1 and 2
        add_entry(enc_i(F3_ADD_SUB, 5'd25, 5'd0, 12'd100), 2, 5'd25, 64'd100, 1'b0);
        add_entry(enc_r(F7_BASE, F3_ADD_SUB, 5'd26, 5'd25, 5'd1), 0, 5'd26, 64'd105, 1'b0);
        add_entry(enc_r(F7_ALT, F3_ADD_SUB, 5'd27, 5'd1, 5'd26), 0, 5'd27, -64'd100, 1'b0);
        add_entry(enc_i(F3_ADD_SUB, 5'd28, 5'd0, 12'd7), 2, 5'd28, 64'd7, 1'b0);
        add_entry(enc_r(F7_BASE, F3_OR, 5'd29, 5'd0, 5'd28), 1, 5'd29, 64'd7, 1'b0);
        add_entry(enc_r(F7_BASE, F3_XOR, 5'd30, 5'd29, 5'd1), 1, 5'd30, 64'd2, 1'b0);
        add_entry(enc_r(F7_BASE, F3_SLL, 5'd31, 5'd30, 5'd30), 2, 5'd31, 64'd8, 1'b0);
        add_entry(enc_i(F3_ADD_SUB, 5'd1, 5'd0, 12'd3), 0, 5'd1, 64'd3, 1'b0);
        add_entry(enc_r(F7_BASE, F3_ADD_SUB, 5'd2, 5'd1, 5'd1), 0, 5'd2, 64'd6, 1'b0);
        add_entry(enc_sh(6'd0, F3_SLL, 5'd3, 5'd2, 6'd1), 0, 5'd3, 64'd12, 1'b0);
        // x0 as destination and then as source
        add_entry(enc_i(F3_ADD_SUB, 5'd0, 5'd1, 12'd9), 1, 5'd0, 64'd0, 1'b0);
        add_entry(enc_r(F7_BASE, F3_OR, 5'd4, 5'd0, 5'd0), 0, 5'd4, 64'd0, 1'b0);
        add_entry(enc_r(F7_ALT, F3_ADD_SUB, 5'd5, 5'd3, 5'd0), 0, 5'd5, 64'd12, 1'b0);
        // load, mul, alternate sll, alternate slli
        add_entry({12'h000, 5'd1, 3'b010, 5'd6, 7'b0000011}, 1, 5'd0, 64'd0, 1'b1);
        add_entry(enc_r(7'b0000001, F3_ADD_SUB, 5'd7, 5'd1, 5'd2), 0, 5'd0, 64'd0, 1'b1);
        add_entry(enc_r(F7_ALT, F3_SLL, 5'd8, 5'd1, 5'd2), 0, 5'd0, 64'd0, 1'b1);
        add_entry(enc_sh(F6_SRA_SUB, F3_SLL, 5'd9, 5'd1, 6'd1), 0, 5'd0, 64'd0, 1'b1);
        add_entry(enc_r(F7_BASE, F3_ADD_SUB, 5'd10, 5'd6, 5'd0), 0, 5'd10, -64'd6, 1'b0);
        add_entry(enc_r(F7_BASE, F3_OR, 5'd11, 5'd7, 5'd8), 0, 5'd11, 64'hFD, 1'b0);
        add_entry(enc_r(F7_BASE, F3_ADD_SUB, 5'd12, 5'd9, 5'd0), 0, 5'd12, 64'h5 << 60, 1'b0);
    endtask

    // gap idle cycles and then one strobed instruction
    task automatic issue(input inst_t w, input int gap, input reg_addr_t addr,
                         input xdata_t data, input logic bad);
        repeat (gap) begin
            @(negedge clk);
            inst_valid = 1'b0;
        end
        @(negedge clk);
        inst       = w;
        inst_valid = 1'b1;
        if (bad || addr != '0) begin
            exp_cyc_q.push_back(cyc_cnt + 2);
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(data);
            exp_bad_q.push_back(bad);
        end
    endtask

    // strobes are stable around the falling edge
    initial begin : monitor
        forever begin
            @(negedge clk);
            if (rst_n && (wb_valid || bad_inst)) begin
                if (exp_cyc_q.size() == 0) begin
                    abort_run("strobe seen with no instruction outstanding");
                end else begin
                    check_eq(64'(cyc_cnt), 64'(exp_cyc_q[0]), "strobe cycle");
                    check_eq(64'(bad_inst), 64'(exp_bad_q[0]), "bad_inst");
                    check_eq(64'(wb_valid), 64'(!exp_bad_q[0]), "wb_valid");
                    if (!exp_bad_q[0]) begin
                        check_eq(64'(wb_addr), 64'(exp_addr_q[0]), "wb_addr");
                        check_eq(wb_data, exp_data_q[0], "wb_data");
                    end
                    void'(exp_cyc_q.pop_front());
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_bad_q.pop_front());
                end
            end else if (exp_cyc_q.size() != 0 && exp_cyc_q[0] < cyc_cnt) begin
                abort_run("an expected strobe did not appear in time");
            end
        end
    end

    initial begin : stimulus
        inst_t       w;
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        xdata_t      exp;
        int          timeout;

        void'($urandom(32'h4345_b20e));
        inst       = '0;
        inst_valid = 1'b0;
        rst_n      = 1'b0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        build_table();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < tbl_inst.size(); i++) begin
            issue(tbl_inst[i], tbl_gap[i], tbl_addr[i], tbl_data[i], tbl_bad[i]);
            if (!tbl_bad[i] && tbl_addr[i] != '0) begin
                ref_regs[tbl_addr[i]] = tbl_data[i];
            end
        end

        // registers limited to x0..x7 so that hazards come often
        for (int n = 0; n < RAND_COUNT; n++) begin
            rnd = $urandom;
            f3  = rnd[14:12];
            rd  = {2'b00, rnd[9:7]};
            rs1 = {2'b00, rnd[17:15]};
            rs2 = {2'b00, rnd[22:20]};
            if (rnd[0]) begin
                f7 = (rnd[1] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)) ? F7_ALT : F7_BASE;
                w  = enc_r(f7, f3, rd, rs1, rs2);
            end else if (f3 == F3_SLL) begin
                w = enc_sh(6'd0, f3, rd, rs1, rnd[30:25]);
            end else if (f3 == F3_SRL_SRA) begin
                w = enc_sh(rnd[1] ? F6_SRA_SUB : 6'd0, f3, rd, rs1, rnd[30:25]);
            end else begin
                w = enc_i(f3, rd, rs1, rnd[31:20]);
            end
            exp = ref_result(w, ref_regs[rs1], ref_regs[rs2]);
            issue(w, int'(rnd[3:2]), rd, exp, 1'b0);
            if (rd != '0) begin
                ref_regs[rd] = exp;
            end
        end

        @(negedge clk);
        inst_valid = 1'b0;
        timeout    = 0;
        while (exp_cyc_q.size() != 0 && timeout < DRAIN_TIMEOUT) begin
            @(negedge clk);
            timeout++;
        end
        if (exp_cyc_q.size() != 0) begin
            abort_run("timed out waiting for outstanding writebacks");
        end else begin
            // a few idle cycles to catch a late stray strobe
            repeat (4) @(negedge clk);
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
common/rv_isa_pkg.sv
common/core_pkg.sv
hdl/regfile.sv
hdl/id_stage.sv
hdl/exe_stage.sv
hdl/core_top.sv
verification/tb_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the core testbench with Verilator, runs it and decides the result from the log

set -u

ROOT_DIR="$(cd "$(dirname "$0")" && pwd)"
BUILD_DIR="$ROOT_DIR/obj_dir"
LOG_FILE="$ROOT_DIR/sim.log"

cd "$ROOT_DIR" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f sim.f --top-module tb_core -Mdir "$BUILD_DIR" -o sim_core
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

"$BUILD_DIR/sim_core" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Test passed" "$LOG_FILE"; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi
